// File: filelist.f
+incdir+design
design/pe_pkg.sv
design/periph_bus_if.sv
design/bus_decoder.sv
design/rtc_timer.sv
design/plic_gate.sv
design/br_local_port.sv
design/pe_periph_top.sv
verification/pe_periph_tb.sv

// File: Makefile
TOP = pe_periph_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/pe_periph_tb.sv
`timescale 1ns/1ps

`include "pe_params.svh"

module pe_periph_tb;

    localparam int                   N_RANDOM   = 3000;
    localparam int                   TIMER_WAIT = 200;
    localparam int                   MSVC_W     = $clog2(`BR_MON_NSVC);
    // PE (x=1, y=2) in a 4-wide mesh
    localparam logic [`BR_SEQ_W-1:0] SEQ_EXP    = 16'd9;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      cpu_en_i;
    logic [`PE_STRB_W-1:0]     cpu_we_i;
    logic [`PE_ADDR_W-1:0]     cpu_addr_i;
    logic [`PE_DATA_W-1:0]     cpu_wdata_i;
    logic [`PE_DATA_W-1:0]     dmem_rdata_i;
    logic [`PE_DATA_W-1:0]     ni_rdata_i;
    logic                      ni_irq_i;
    logic                      irq_ack_i;
    logic                      br_req_i;
    pe_pkg::br_flit_t          br_flit_i;
    logic                      mon_ack_i;
    logic                      svc_ack_i;
    logic                      ni_req_i;
    pe_pkg::br_out_t           ni_flit_i;
    logic                      inj_ack_i;

    logic [`PE_DATA_W-1:0]     cpu_rdata_o;
    logic                      dmem_en_o;
    logic                      ni_en_o;
    logic [`PE_MEM_ADDR_W-1:0] dmem_addr_o;
    logic [`PE_DATA_W-1:0]     irq_o;
    logic [`MTIME_W-1:0]       mtime_o;
    logic                      br_ack_o;
    logic                      mon_req_o;
    pe_pkg::br_mon_t           mon_flit_o;
    logic                      svc_req_o;
    pe_pkg::br_svc_t           svc_flit_o;
    logic                      ni_ack_o;
    logic                      inj_req_o;
    pe_pkg::br_flit_t          inj_flit_o;

    // Reference model state
    logic [`MTIME_W-1:0]       m_mtime;
    logic [`MTIME_W-1:0]       m_mtimecmp;
    logic                      m_enable;
    logic                      m_pending;
    logic [`BR_ID_W-1:0]       m_id;
    logic [`PE_DATA_W-1:0]     m_rdata;
    logic                      m_rdata_valid;

    pe_periph_top #(
        .PE_ADDRESS (16'h0102),
        .N_PE_X     (4)
    ) dut (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .cpu_en_i     (cpu_en_i    ),
        .cpu_we_i     (cpu_we_i    ),
        .cpu_addr_i   (cpu_addr_i  ),
        .cpu_wdata_i  (cpu_wdata_i ),
        .cpu_rdata_o  (cpu_rdata_o ),
        .dmem_rdata_i (dmem_rdata_i),
        .ni_rdata_i   (ni_rdata_i  ),
        .dmem_en_o    (dmem_en_o   ),
        .ni_en_o      (ni_en_o     ),
        .dmem_addr_o  (dmem_addr_o ),
        .ni_irq_i     (ni_irq_i    ),
        .irq_ack_i    (irq_ack_i   ),
        .irq_o        (irq_o       ),
        .mtime_o      (mtime_o     ),
        .br_req_i     (br_req_i    ),
        .br_flit_i    (br_flit_i   ),
        .br_ack_o     (br_ack_o    ),
        .mon_req_o    (mon_req_o   ),
        .mon_flit_o   (mon_flit_o  ),
        .mon_ack_i    (mon_ack_i   ),
        .svc_req_o    (svc_req_o   ),
        .svc_flit_o   (svc_flit_o  ),
        .svc_ack_i    (svc_ack_i   ),
        .ni_req_i     (ni_req_i    ),
        .ni_flit_i    (ni_flit_i   ),
        .ni_ack_o     (ni_ack_o    ),
        .inj_req_o    (inj_req_o   ),
        .inj_flit_o   (inj_flit_o  ),
        .inj_ack_i    (inj_ack_i   )
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Replace only the byte lanes whose strobe is set
    function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                  input logic [31:0] new_w,
                                                  input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic drive_random();
        logic [7:0]  rgn;
        logic [31:0] mid;
        case ($urandom_range(0, 5))
            0:       rgn = pe_pkg::REGION_IMEM;
            1:       rgn = pe_pkg::REGION_DMEM;
            2:       rgn = pe_pkg::REGION_RTC;
            3:       rgn = pe_pkg::REGION_PLIC;
            4:       rgn = pe_pkg::REGION_NI;
            default: rgn = 8'($urandom);
        endcase
        mid        = $urandom;
        cpu_en_i   = ($urandom_range(0, 3) != 0);
        cpu_addr_i = {rgn, mid[19:0], 4'($urandom_range(0, 3) * 4)};
        cpu_we_i   = $urandom_range(0, 1) ? 4'h0 : 4'($urandom_range(1, 15));
        // Small values let the compare actually trip
        case ($urandom_range(0, 2))
            0:       cpu_wdata_i = '0;
            1:       cpu_wdata_i = $urandom_range(0, 1000);
            default: cpu_wdata_i = $urandom;
        endcase
        dmem_rdata_i         = $urandom;
        ni_rdata_i           = $urandom;
        ni_irq_i             = ($urandom_range(0, 7) == 0);
        irq_ack_i            = ($urandom_range(0, 3) == 0);
        br_req_i             = 1'($urandom);
        br_flit_i.payload    = $urandom;
        br_flit_i.seq_target = 16'($urandom);
        br_flit_i.seq_source = 16'($urandom);
        br_flit_i.producer   = 16'($urandom);
        br_flit_i.ksvc       = 8'($urandom);
        br_flit_i.id         = 5'($urandom);
        br_flit_i.service    = pe_pkg::br_svc_e'(3'($urandom_range(0, 3)));
        mon_ack_i            = 1'($urandom);
        svc_ack_i            = 1'($urandom);
        ni_req_i             = 1'($urandom);
        ni_flit_i.payload    = $urandom;
        ni_flit_i.seq_target = 16'($urandom);
        ni_flit_i.producer   = 16'($urandom);
        ni_flit_i.ksvc       = 8'($urandom);
        ni_flit_i.service    = pe_pkg::br_svc_e'(3'($urandom_range(0, 3)));
        inj_ack_i            = 1'($urandom);
    endtask

    task automatic drive_cpu_write(input logic [7:0] rgn, input logic [3:0] ofs,
                                   input logic [31:0] data);
        cpu_en_i    = 1'b1;
        cpu_we_i    = 4'hF;
        cpu_addr_i  = {rgn, 20'h0, ofs};
        cpu_wdata_i = data;
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Called just after an edge while the previous inputs are still applied
    task automatic update_model();
        logic [7:0] rgn;
        logic [3:0] ofs;
        rgn     = cpu_addr_i[`PE_REGION_HI:`PE_REGION_LO];
        ofs     = cpu_addr_i[3:0];
        m_mtime = m_mtime + 1;
        if (cpu_en_i && rgn == pe_pkg::REGION_RTC && cpu_we_i != 4'h0) begin
            if (ofs == pe_pkg::RTC_MTIMECMP_LO) begin
                m_mtimecmp[31:0] = apply_strobes(m_mtimecmp[31:0], cpu_wdata_i, cpu_we_i);
            end else if (ofs == pe_pkg::RTC_MTIMECMP_HI) begin
                m_mtimecmp[63:32] = apply_strobes(m_mtimecmp[63:32], cpu_wdata_i, cpu_we_i);
            end
        end
        if (cpu_en_i && rgn == pe_pkg::REGION_PLIC && cpu_we_i[0]
            && ofs == pe_pkg::PLIC_ENABLE) begin
            m_enable = cpu_wdata_i[0];
        end
        if (ni_irq_i) begin
            m_pending = 1'b1;
        end else if (irq_ack_i) begin
            m_pending = 1'b0;
        end
        if (inj_ack_i) begin
            m_id = m_id + 1'b1;
        end
    endtask

    // Expected read data for the next cycle from the state before the edge
    task automatic expect_read();
        logic [7:0] rgn;
        logic [3:0] ofs;
        rgn           = cpu_addr_i[`PE_REGION_HI:`PE_REGION_LO];
        ofs           = cpu_addr_i[3:0];
        m_rdata_valid = !(cpu_en_i && cpu_we_i != 4'h0);
        m_rdata       = dmem_rdata_i;
        if (cpu_en_i) begin
            if (rgn == pe_pkg::REGION_RTC) begin
                case (ofs)
                    pe_pkg::RTC_MTIME_LO:    m_rdata = m_mtime[31:0];
                    pe_pkg::RTC_MTIME_HI:    m_rdata = m_mtime[63:32];
                    pe_pkg::RTC_MTIMECMP_LO: m_rdata = m_mtimecmp[31:0];
                    default:                 m_rdata = m_mtimecmp[63:32];
                endcase
            end else if (rgn == pe_pkg::REGION_PLIC) begin
                case (ofs)
                    pe_pkg::PLIC_ENABLE:  m_rdata = {31'b0, m_enable};
                    pe_pkg::PLIC_PENDING: m_rdata = {31'b0, m_pending};
                    default:              m_rdata = '0;
                endcase
            end else if (rgn == pe_pkg::REGION_NI) begin
                m_rdata = ni_rdata_i;
            end
        end
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic tick_and_check();
        logic [31:0] exp_irq;
        @(posedge clk_i);
        update_model();
        #1;
        exp_irq               = '0;
        exp_irq[`IRQ_MTI_BIT] = (m_mtime >= m_mtimecmp);
        exp_irq[`IRQ_MEI_BIT] = m_enable & m_pending;
        check_value("mtime_o", m_mtime, mtime_o);
        check_value("irq_o", exp_irq, irq_o);
        if (m_rdata_valid) begin
            check_value("cpu_rdata_o", m_rdata, cpu_rdata_o);
        end
    endtask

    task automatic check_combinational();
        logic             is_mon;
        logic [7:0]       rgn;
        pe_pkg::br_mon_t  exp_mon;
        pe_pkg::br_svc_t  exp_svc;
        pe_pkg::br_flit_t exp_inj;
        rgn    = cpu_addr_i[`PE_REGION_HI:`PE_REGION_LO];
        is_mon = (br_flit_i.service == pe_pkg::BR_SVC_MON);
        check_value("dmem_en_o", cpu_en_i && rgn == pe_pkg::REGION_DMEM, dmem_en_o);
        check_value("ni_en_o", cpu_en_i && rgn == pe_pkg::REGION_NI, ni_en_o);
        check_value("dmem_addr_o", cpu_addr_i[`PE_MEM_ADDR_W-1:0], dmem_addr_o);

        check_value("mon_req_o", br_req_i && is_mon, mon_req_o);
        check_value("svc_req_o", br_req_i && !is_mon, svc_req_o);
        check_value("br_ack_o", is_mon ? mon_ack_i : svc_ack_i, br_ack_o);
        exp_mon.payload    = br_flit_i.payload;
        exp_mon.seq_source = br_flit_i.seq_source;
        exp_mon.producer   = br_flit_i.producer;
        exp_mon.msvc       = br_flit_i.ksvc[MSVC_W-1:0];
        exp_svc.payload    = br_flit_i.payload;
        exp_svc.seq_source = br_flit_i.seq_source;
        exp_svc.producer   = br_flit_i.producer;
        exp_svc.ksvc       = br_flit_i.ksvc;
        check_value("mon_flit_o", exp_mon, mon_flit_o);
        check_value("svc_flit_o", exp_svc, svc_flit_o);

        exp_inj.payload    = ni_flit_i.payload;
        exp_inj.seq_target = ni_flit_i.seq_target;
        exp_inj.seq_source = SEQ_EXP;
        exp_inj.producer   = ni_flit_i.producer;
        exp_inj.ksvc       = ni_flit_i.ksvc;
        exp_inj.id         = m_id;
        exp_inj.service    = ni_flit_i.service;
        check_value("inj_req_o", ni_req_i, inj_req_o);
        check_value("ni_ack_o", inj_ack_i, ni_ack_o);
        check_value("inj_flit_o", exp_inj, inj_flit_o);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int   waited;
        logic mti_seen;
        void'($urandom(32'hd430));
        rst_ni        = 1'b0;
        cpu_en_i      = 1'b0;
        cpu_we_i      = '0;
        cpu_addr_i    = '0;
        cpu_wdata_i   = '0;
        dmem_rdata_i  = '0;
        ni_rdata_i    = '0;
        ni_irq_i      = 1'b0;
        irq_ack_i     = 1'b0;
        br_req_i      = 1'b0;
        br_flit_i     = '0;
        mon_ack_i     = 1'b0;
        svc_ack_i     = 1'b0;
        ni_req_i      = 1'b0;
        ni_flit_i     = '0;
        inj_ack_i     = 1'b0;
        m_mtime       = '0;
        m_mtimecmp    = '1;
        m_enable      = 1'b0;
        m_pending     = 1'b0;
        m_id          = '0;
        m_rdata       = '0;
        m_rdata_valid = 1'b0;

        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_value("mtime_o", 64'h0, mtime_o);
        check_value("irq_o", 32'h0, irq_o);

        for (int i = 0; i < N_RANDOM; i++) begin
            tick_and_check();
            drive_random();
            #1;
            check_combinational();
            expect_read();
        end

        // Program the compare a little ahead of the count
        tick_and_check();
        drive_random();
        drive_cpu_write(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_HI, 32'h0);
        #1;
        check_combinational();
        expect_read();
        tick_and_check();
        drive_random();
        drive_cpu_write(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_LO, m_mtime[31:0] + 40);
        #1;
        check_combinational();
        expect_read();

        waited   = 0;
        mti_seen = 1'b0;
        while (!mti_seen && waited < TIMER_WAIT) begin
            tick_and_check();
            mti_seen = irq_o[`IRQ_MTI_BIT];
            drive_random();
            cpu_en_i = 1'b0;
            #1;
            check_combinational();
            expect_read();
            waited++;
        end

        if (!mti_seen) begin
            $display("Timer interrupt did not rise within %0d cycles of setting mtimecmp",
                     TIMER_WAIT);
            $display("ERRORS FOUND");
            $fatal(1, "Timer interrupt timeout");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: design/pe_periph_top.sv
`timescale 1ns/1ps

`include "pe_params.svh"

module pe_periph_top #(
    parameter logic [15:0] PE_ADDRESS = 16'h0000,
    parameter int          N_PE_X     = 2
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Core data bus
    input  logic                      cpu_en_i,
    input  logic [`PE_STRB_W-1:0]     cpu_we_i,
    input  logic [`PE_ADDR_W-1:0]     cpu_addr_i,
    input  logic [`PE_DATA_W-1:0]     cpu_wdata_i,
    output logic [`PE_DATA_W-1:0]     cpu_rdata_o,
    input  logic [`PE_DATA_W-1:0]     dmem_rdata_i,
    input  logic [`PE_DATA_W-1:0]     ni_rdata_i,
    output logic                      dmem_en_o,
    output logic                      ni_en_o,
    output logic [`PE_MEM_ADDR_W-1:0] dmem_addr_o,

    // Interrupts and time
    input  logic                      ni_irq_i,
    input  logic                      irq_ack_i,
    output logic [`PE_DATA_W-1:0]     irq_o,
    output logic [`MTIME_W-1:0]       mtime_o,

    // Broadcast router local port
    input  logic                      br_req_i,
    input  pe_pkg::br_flit_t          br_flit_i,
    output logic                      br_ack_o,
    output logic                      mon_req_o,
    output pe_pkg::br_mon_t           mon_flit_o,
    input  logic                      mon_ack_i,
    output logic                      svc_req_o,
    output pe_pkg::br_svc_t           svc_flit_o,
    input  logic                      svc_ack_i,
    input  logic                      ni_req_i,
    input  pe_pkg::br_out_t           ni_flit_i,
    output logic                      ni_ack_o,
    output logic                      inj_req_o,
    output pe_pkg::br_flit_t          inj_flit_o,
    input  logic                      inj_ack_i
);

    // Sequential PE number, y * N_PE_X + x
    localparam logic [`BR_SEQ_W-1:0] SEQ_ADDRESS =
        `BR_SEQ_W'(PE_ADDRESS[7:0] * N_PE_X + PE_ADDRESS[15:8]);

    ////////////////////////////////////////
    // Memory map and devices
    ////////////////////////////////////////

    periph_bus_if rtc_bus ();
    periph_bus_if plic_bus ();

    logic mti;
    logic mei;

    assign dmem_addr_o = cpu_addr_i[`PE_MEM_ADDR_W-1:0];

    bus_decoder u_decoder (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .cpu_en_i     (cpu_en_i    ),
        .cpu_we_i     (cpu_we_i    ),
        .cpu_addr_i   (cpu_addr_i  ),
        .cpu_wdata_i  (cpu_wdata_i ),
        .dmem_rdata_i (dmem_rdata_i),
        .ni_rdata_i   (ni_rdata_i  ),
        .cpu_rdata_o  (cpu_rdata_o ),
        .dmem_en_o    (dmem_en_o   ),
        .ni_en_o      (ni_en_o     ),
        .rtc_bus      (rtc_bus     ),
        .plic_bus     (plic_bus    )
    );

    rtc_timer u_rtc (
        .clk_i   (clk_i  ),
        .rst_ni  (rst_ni ),
        .bus     (rtc_bus),
        .mti_o   (mti    ),
        .mtime_o (mtime_o)
    );

    plic_gate u_plic (
        .clk_i     (clk_i    ),
        .rst_ni    (rst_ni   ),
        .bus       (plic_bus ),
        .src_irq_i (ni_irq_i ),
        .iack_i    (irq_ack_i),
        .irq_o     (mei      )
    );

    // Only the timer and external lines are used
    always_comb begin
        irq_o               = '0;
        irq_o[`IRQ_MTI_BIT] = mti;
        irq_o[`IRQ_MEI_BIT] = mei;
    end

    ////////////////////////////////////////
    // Broadcast local port
    ////////////////////////////////////////

    br_local_port #(
        .SEQ_ADDRESS (SEQ_ADDRESS)
    ) u_br_port (
        .clk_i      (clk_i     ),
        .rst_ni     (rst_ni    ),
        .br_req_i   (br_req_i  ),
        .br_flit_i  (br_flit_i ),
        .br_ack_o   (br_ack_o  ),
        .mon_req_o  (mon_req_o ),
        .mon_flit_o (mon_flit_o),
        .mon_ack_i  (mon_ack_i ),
        .svc_req_o  (svc_req_o ),
        .svc_flit_o (svc_flit_o),
        .svc_ack_i  (svc_ack_i ),
        .ni_req_i   (ni_req_i  ),
        .ni_flit_i  (ni_flit_i ),
        .ni_ack_o   (ni_ack_o  ),
        .inj_req_o  (inj_req_o ),
        .inj_flit_o (inj_flit_o),
        .inj_ack_i  (inj_ack_i )
    );

endmodule

// File: design/br_local_port.sv
`timescale 1ns/1ps

`include "pe_params.svh"

module br_local_port #(
    parameter logic [`BR_SEQ_W-1:0] SEQ_ADDRESS = '0
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             br_req_i,
    input  pe_pkg::br_flit_t br_flit_i,
    output logic             br_ack_o,
    output logic             mon_req_o,
    output pe_pkg::br_mon_t  mon_flit_o,
    input  logic             mon_ack_i,
    output logic             svc_req_o,
    output pe_pkg::br_svc_t  svc_flit_o,
    input  logic             svc_ack_i,
    input  logic             ni_req_i,
    input  pe_pkg::br_out_t  ni_flit_i,
    output logic             ni_ack_o,
    output logic             inj_req_o,
    output pe_pkg::br_flit_t inj_flit_o,
    input  logic             inj_ack_i
);

    ////////////////////////////////////////
    // Delivery to the NI
    ////////////////////////////////////////

    logic is_mon;

    assign is_mon    = (br_flit_i.service == pe_pkg::BR_SVC_MON);
    assign mon_req_o = br_req_i && is_mon;
    assign svc_req_o = br_req_i && !is_mon;
    assign br_ack_o  = is_mon ? mon_ack_i : svc_ack_i;

    assign mon_flit_o.payload    = br_flit_i.payload;
    assign mon_flit_o.seq_source = br_flit_i.seq_source;
    assign mon_flit_o.producer   = br_flit_i.producer;
    // Monitor kind sits in the low ksvc bits
    assign mon_flit_o.msvc       = br_flit_i.ksvc[$clog2(`BR_MON_NSVC)-1:0];

    assign svc_flit_o.payload    = br_flit_i.payload;
    assign svc_flit_o.seq_source = br_flit_i.seq_source;
    assign svc_flit_o.producer   = br_flit_i.producer;
    assign svc_flit_o.ksvc       = br_flit_i.ksvc;

    ////////////////////////////////////////
    // Injection from the NI
    ////////////////////////////////////////

    logic [`BR_ID_W-1:0] id_q;

    // Rolls over, one step per accepted flit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_q <= '0;
        end else if (inj_ack_i) begin
            id_q <= id_q + 1'b1;
        end
    end

    assign inj_req_o = ni_req_i;
    assign ni_ack_o  = inj_ack_i;

    assign inj_flit_o.payload    = ni_flit_i.payload;
    assign inj_flit_o.seq_target = ni_flit_i.seq_target;
    assign inj_flit_o.seq_source = SEQ_ADDRESS;
    assign inj_flit_o.producer   = ni_flit_i.producer;
    assign inj_flit_o.ksvc       = ni_flit_i.ksvc;
    assign inj_flit_o.id         = id_q;
    assign inj_flit_o.service    = ni_flit_i.service;

    a_one_stream: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(mon_req_o && svc_req_o)
    );

endmodule

// File: design/plic_gate.sv
`timescale 1ns/1ps

`include "pe_params.svh"

module plic_gate (
    input  logic         clk_i,
    input  logic         rst_ni,
    periph_bus_if.device bus,
    input  logic         src_irq_i,
    input  logic         iack_i,
    output logic         irq_o
);

    logic                  enable_q;
    logic                  pending_q;
    logic [`PE_DATA_W-1:0] rdata_q;
    logic                  enable_wr;

    // Only byte lane 0 carries the enable bit
    assign enable_wr = bus.sel && bus.we[0] && (bus.addr == pe_pkg::PLIC_ENABLE);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (enable_wr) begin
            enable_q <= bus.wdata[0];
        end
    end

    // A new request wins over the ack in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (src_irq_i) begin
            pending_q <= 1'b1;
        end else if (iack_i) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.sel) begin
            case (bus.addr)
                pe_pkg::PLIC_ENABLE:  rdata_q <= {{(`PE_DATA_W-1){1'b0}}, enable_q};
                pe_pkg::PLIC_PENDING: rdata_q <= {{(`PE_DATA_W-1){1'b0}}, pending_q};
                default:              rdata_q <= '0;
            endcase
        end
    end

    assign bus.rdata = rdata_q;
    assign irq_o     = pending_q & enable_q;

    // Never raised while disabled
    a_irq_gated: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        irq_o |-> enable_q
    );

endmodule

// File: design/rtc_timer.sv
`timescale 1ns/1ps

`include "pe_params.svh"

module rtc_timer (
    input  logic                clk_i,
    input  logic                rst_ni,
    periph_bus_if.device        bus,
    output logic                mti_o,
    output logic [`MTIME_W-1:0] mtime_o
);

    localparam int WORD_W = `PE_DATA_W;

    logic [`MTIME_W-1:0]   mtime_q;
    logic [`MTIME_W-1:0]   mtimecmp_q;
    logic [`PE_DATA_W-1:0] rdata_q;
    logic                  wr_en;

    // Byte-lane merge for strobed writes
    function automatic logic [WORD_W-1:0] merge_bytes(
        input logic [WORD_W-1:0]     old_w,
        input logic [WORD_W-1:0]     new_w,
        input logic [`PE_STRB_W-1:0] strb
    );
        logic [WORD_W-1:0] res;
        res = old_w;
        for (int i = 0; i < `PE_STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en = bus.sel && (|bus.we);

    // Free-running, counts edges since reset release
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // Compare starts at all ones so no interrupt fires before setup
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else if (wr_en) begin
            case (bus.addr)
                pe_pkg::RTC_MTIMECMP_LO: begin
                    mtimecmp_q[WORD_W-1:0] <=
                        merge_bytes(mtimecmp_q[WORD_W-1:0], bus.wdata, bus.we);
                end
                pe_pkg::RTC_MTIMECMP_HI: begin
                    mtimecmp_q[`MTIME_W-1:WORD_W] <=
                        merge_bytes(mtimecmp_q[`MTIME_W-1:WORD_W], bus.wdata, bus.we);
                end
                default: ;
            endcase
        end
    end

    // Value sampled at the request edge
    always_ff @(posedge clk_i) begin
        if (bus.sel) begin
            case (bus.addr)
                pe_pkg::RTC_MTIME_LO:    rdata_q <= mtime_q[WORD_W-1:0];
                pe_pkg::RTC_MTIME_HI:    rdata_q <= mtime_q[`MTIME_W-1:WORD_W];
                pe_pkg::RTC_MTIMECMP_LO: rdata_q <= mtimecmp_q[WORD_W-1:0];
                pe_pkg::RTC_MTIMECMP_HI: rdata_q <= mtimecmp_q[`MTIME_W-1:WORD_W];
                default:                 rdata_q <= '0;
            endcase
        end
    end

    assign bus.rdata = rdata_q;
    assign mti_o     = (mtime_q >= mtimecmp_q);
    assign mtime_o   = mtime_q;

    a_mtime_mono: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ($past(mtime_q) != '1) |-> (mtime_q >= $past(mtime_q))
    );

endmodule

// File: design/bus_decoder.sv
`timescale 1ns/1ps

`include "pe_params.svh"

module bus_decoder (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  cpu_en_i,
    input  logic [`PE_STRB_W-1:0] cpu_we_i,
    input  logic [`PE_ADDR_W-1:0] cpu_addr_i,
    input  logic [`PE_DATA_W-1:0] cpu_wdata_i,
    input  logic [`PE_DATA_W-1:0] dmem_rdata_i,
    input  logic [`PE_DATA_W-1:0] ni_rdata_i,
    output logic [`PE_DATA_W-1:0] cpu_rdata_o,
    output logic                  dmem_en_o,
    output logic                  ni_en_o,
    periph_bus_if.decoder         rtc_bus,
    periph_bus_if.decoder         plic_bus
);

    ////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////

    pe_pkg::region_e region;

    always_comb begin
        case (cpu_addr_i[`PE_REGION_HI:`PE_REGION_LO])
            pe_pkg::REGION_IMEM: region = pe_pkg::REGION_IMEM;
            pe_pkg::REGION_DMEM: region = pe_pkg::REGION_DMEM;
            pe_pkg::REGION_RTC:  region = pe_pkg::REGION_RTC;
            pe_pkg::REGION_PLIC: region = pe_pkg::REGION_PLIC;
            pe_pkg::REGION_NI:   region = pe_pkg::REGION_NI;
            default:             region = pe_pkg::REGION_NONE;
        endcase
    end

    assign dmem_en_o    = cpu_en_i && (region == pe_pkg::REGION_DMEM);
    assign ni_en_o      = cpu_en_i && (region == pe_pkg::REGION_NI);
    assign rtc_bus.sel  = cpu_en_i && (region == pe_pkg::REGION_RTC);
    assign plic_bus.sel = cpu_en_i && (region == pe_pkg::REGION_PLIC);

    // Both devices see the same request fields
    assign rtc_bus.we     = cpu_we_i;
    assign rtc_bus.addr   = cpu_addr_i[`PE_REG_OFS_W-1:0];
    assign rtc_bus.wdata  = cpu_wdata_i;
    assign plic_bus.we    = cpu_we_i;
    assign plic_bus.addr  = cpu_addr_i[`PE_REG_OFS_W-1:0];
    assign plic_bus.wdata = cpu_wdata_i;

    ////////////////////////////////////////
    // Read-back
    ////////////////////////////////////////

    logic rtc_sel_q;
    logic plic_sel_q;
    logic ni_sel_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rtc_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
            ni_sel_q   <= 1'b0;
        end else begin
            rtc_sel_q  <= rtc_bus.sel;
            plic_sel_q <= plic_bus.sel;
            ni_sel_q   <= ni_en_o;
        end
    end

    // Data memory answers when no device was selected
    always_comb begin
        if (rtc_sel_q) begin
            cpu_rdata_o = rtc_bus.rdata;
        end else if (plic_sel_q) begin
            cpu_rdata_o = plic_bus.rdata;
        end else if (ni_sel_q) begin
            cpu_rdata_o = ni_rdata_i;
        end else begin
            cpu_rdata_o = dmem_rdata_i;
        end
    end

    a_one_sel: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0({rtc_sel_q, plic_sel_q, ni_sel_q})
    );

endmodule

// File: design/periph_bus_if.sv
`timescale 1ns/1ps

`include "pe_params.svh"

interface periph_bus_if;

    logic                     sel;
    logic [`PE_STRB_W-1:0]    we;
    logic [`PE_REG_OFS_W-1:0] addr;
    logic [`PE_DATA_W-1:0]    wdata;
    // Registered in the device, valid the cycle after sel
    logic [`PE_DATA_W-1:0]    rdata;

    modport decoder (
        output sel, we, addr, wdata,
        input  rdata
    );

    modport device (
        input  sel, we, addr, wdata,
        output rdata
    );

endinterface

// File: design/pe_pkg.sv
package pe_pkg;

`include "pe_params.svh"

    // Address regions, taken from the top byte of the address
    typedef enum logic [7:0] {
        REGION_IMEM = `PE_RGN_IMEM,
        REGION_DMEM = `PE_RGN_DMEM,
        REGION_RTC  = `PE_RGN_RTC,
        REGION_PLIC = `PE_RGN_PLIC,
        REGION_NI   = `PE_RGN_NI,
        REGION_NONE = `PE_RGN_NONE
    } region_e;

    typedef enum logic [`PE_REG_OFS_W-1:0] {
        RTC_MTIME_LO    = `RTC_OFS_MTIME_LO,
        RTC_MTIME_HI    = `RTC_OFS_MTIME_HI,
        RTC_MTIMECMP_LO = `RTC_OFS_MTIMECMP_LO,
        RTC_MTIMECMP_HI = `RTC_OFS_MTIMECMP_HI
    } rtc_reg_e;

    typedef enum logic [`PE_REG_OFS_W-1:0] {
        PLIC_ENABLE  = `PLIC_OFS_ENABLE,
        PLIC_PENDING = `PLIC_OFS_PENDING
    } plic_reg_e;

    // Monitoring goes to its own stream, the rest are kernel services
    typedef enum logic [2:0] {
        BR_SVC_TGT = 3'd0,
        BR_SVC_ALL = 3'd1,
        BR_SVC_CLR = 3'd2,
        BR_SVC_MON = 3'd3
    } br_svc_e;

    // Flit as seen by the broadcast router
    typedef struct packed {
        logic [`BR_PAYLOAD_W-1:0] payload;
        logic [`BR_SEQ_W-1:0]     seq_target;
        logic [`BR_SEQ_W-1:0]     seq_source;
        logic [`BR_SEQ_W-1:0]     producer;
        logic [`BR_KSVC_W-1:0]    ksvc;
        logic [`BR_ID_W-1:0]      id;
        br_svc_e                  service;
    } br_flit_t;

    // Flit from the NI, source and id are added on injection
    typedef struct packed {
        logic [`BR_PAYLOAD_W-1:0] payload;
        logic [`BR_SEQ_W-1:0]     seq_target;
        logic [`BR_SEQ_W-1:0]     producer;
        logic [`BR_KSVC_W-1:0]    ksvc;
        br_svc_e                  service;
    } br_out_t;

    typedef struct packed {
        logic [`BR_PAYLOAD_W-1:0]       payload;
        logic [`BR_SEQ_W-1:0]           seq_source;
        logic [`BR_SEQ_W-1:0]           producer;
        logic [$clog2(`BR_MON_NSVC)-1:0] msvc;
    } br_mon_t;

    typedef struct packed {
        logic [`BR_PAYLOAD_W-1:0] payload;
        logic [`BR_SEQ_W-1:0]     seq_source;
        logic [`BR_SEQ_W-1:0]     producer;
        logic [`BR_KSVC_W-1:0]    ksvc;
    } br_svc_t;

endpackage

// File: design/pe_params.svh
`ifndef PE_PARAMS_SVH
`define PE_PARAMS_SVH

// Core bus widths
`define PE_ADDR_W       32
`define PE_DATA_W       32
`define PE_STRB_W       4
`define PE_MEM_ADDR_W   24

// Region field of the core address
`define PE_REGION_HI    31
`define PE_REGION_LO    24

// Region codes
`define PE_RGN_IMEM     8'h00
`define PE_RGN_DMEM     8'h01
`define PE_RGN_RTC      8'h02
`define PE_RGN_PLIC     8'h04
`define PE_RGN_NI       8'h08
`define PE_RGN_NONE     8'hFF

// Register offsets inside a device
`define PE_REG_OFS_W         4
`define RTC_OFS_MTIME_LO     4'h0
`define RTC_OFS_MTIME_HI     4'h4
`define RTC_OFS_MTIMECMP_LO  4'h8
`define RTC_OFS_MTIMECMP_HI  4'hC
`define PLIC_OFS_ENABLE      4'h0
`define PLIC_OFS_PENDING     4'h4

// Machine timer
`define MTIME_W         64

// Broadcast flit fields
`define BR_SEQ_W        16
`define BR_ID_W         5
`define BR_PAYLOAD_W    32
`define BR_KSVC_W       8
`define BR_MON_NSVC     4

// Core interrupt vector
`define IRQ_MTI_BIT     7
`define IRQ_MEI_BIT     11

`endif
